// File: project.f
+incdir+src
src/cache_pkg.sv
src/cacheArray.sv
src/cacheController.sv
src/dataCache.sv
verification/memoryModel.sv
verification/dataCache_assertions.sv
verification/tb_dataCache.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_dataCache
RTL_TOP    ?= dataCache
FILELIST   ?= project.f
INC_DIR    ?= src
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
RUN_ARGS   ?= +verilator+error+limit+100
LINT_FLAGS ?= --lint-only

FAIL_MSG := SOME TESTS FAILED
PASS_MSG := ALL TESTS PASSED
SOURCES  := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(shell grep '^src/.*\.sv$$' $(FILELIST))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(INC_DIR)/cache_macros.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+$(INC_DIR) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_dataCache.sv
`timescale 1ns/10ps
`include "cache_macros.svh"

module tb_dataCache import cache_pkg::*; ();

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 16;
    localparam int numDirected = 18;
    localparam int numRandom   = 400;
    localparam int numSets     = 1 << `INDEX_BITS;

    logic       clk;
    logic       rst;
    cpuReqT     cpuReq;
    cpuRespT    cpuResp;
    logic       busy;
    memReqT     memReq;
    logic       memAck;
    dataT       memRdata;
    logic [1:0] memDelay;

    logic [31:0] rngState;
    cpuRespT     expQ [$];  // one expected response per issued request.
    int          checkedCount;

    // shadow copies of memory and of the two-way cache.
    dataT shadowMem [addrT];
    logic shValid [numSets][`NUM_WAYS];
    tagT  shTag   [numSets][`NUM_WAYS];
    dataT shData  [numSets][`NUM_WAYS];
    logic shLru   [numSets];

    dataCache dataCache_i (.*);

    memoryModel memoryModel_i (.delaySel(memDelay), .*);

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    // ##################################################
    // reference model
    // ##################################################

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic dataT fillWord(input addrT wordAddr);
        return ((wordAddr >> 3) * 64'h9e37_79b9_7f4a_7c15) ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    function automatic dataT mergeBytes(input dataT old, input dataT wdata, input maskT wmask);
        dataT merged;
        merged = old;
        for (int b = 0; b < `DATA_WIDTH / 8; b++) begin
            if (wmask[b]) merged[8*b +: 8] = wdata[8*b +: 8];
        end
        return merged;
    endfunction

    function automatic void referenceAccess(input logic write, input addrT addr,
                                            input dataT wdata, input maskT wmask,
                                            output dataT expData, output logic expHit);
        addrT  wordAddr;
        indexT idx;
        tagT   tag;
        int    way;
        int    victim;
        dataT  word;
        wordAddr = {addr[`ADDR_WIDTH-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
        idx      = addr[`OFFSET_BITS +: `INDEX_BITS];
        tag      = addr[`ADDR_WIDTH-1 -: `TAG_BITS];
        word     = shadowMem.exists(wordAddr) ? shadowMem[wordAddr] : fillWord(wordAddr);
        way      = -1;
        for (int w = 0; w < `NUM_WAYS; w++) begin
            if (shValid[idx][w] && shTag[idx][w] == tag) way = w;
        end
        expHit = (way >= 0);
        if (write) begin
            // the store always reaches memory and only a hit changes the cached copy.
            shadowMem[wordAddr] = mergeBytes(word, wdata, wmask);
            if (expHit) shData[idx][way] = mergeBytes(shData[idx][way], wdata, wmask);
            expData = '0;
        end else if (expHit) begin
            expData    = shData[idx][way];
            shLru[idx] = (way == 0);  // the other way is next to go.
        end else begin
            victim = !shValid[idx][0] ? 0 : (!shValid[idx][1] ? 1 : int'(shLru[idx]));
            shValid[idx][victim] = 1'b1;
            shTag[idx][victim]   = tag;
            shData[idx][victim]  = word;
            shLru[idx]           = (victim == 0);
            expData              = word;
        end
    endfunction

    // ##################################################
    // checking
    // ##################################################

    task automatic abortRun();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkData(input string name, input dataT got, input dataT exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkHit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkBusy(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            abortRun();
        end
    endtask

    always @(negedge clk) begin
        cpuRespT exp;
        if (dataCache_i.dataCache_assertions_i.failCount != 0) begin
            $display("a protocol assertion on dataCache failed");
            abortRun();
        end else if (!rst && cpuResp.done) begin
            if (expQ.size() == 0) begin
                $display("done pulse arrived with no request outstanding");
                abortRun();
            end else begin
                exp = expQ.pop_front();
                checkData("cpuResp.rdata", cpuResp.rdata, exp.rdata);
                checkHit("cpuResp.hit", cpuResp.hit, exp.hit);
                checkedCount++;
            end
        end
    end

    initial begin
        #((resetCycles + (numDirected + numRandom) * 12) * clkPeriod);
        $display("timeout, the requests did not complete in the expected number of cycles");
        abortRun();
    end

    // ##################################################
    // stimulus
    // ##################################################

    function automatic addrT wordAt(input int tagSel, input int set);
        return 64'h3c00_0000_0004_0000 + (addrT'(tagSel) << 58) + (addrT'(set) << 3);
    endfunction

    task automatic issueRequest(input logic write, input addrT addr,
                                input dataT wdata, input maskT wmask);
        cpuRespT     exp;
        dataT        expData;
        logic        expHit;
        logic [31:0] r;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        referenceAccess(write, addr, wdata, wmask, expData, expHit);
        exp.done  = 1'b1;
        exp.hit   = expHit;
        exp.rdata = expData;
        expQ.push_back(exp);
        r            = nextRandom();
        memDelay     = r[1:0];
        cpuReq.valid = 1'b1;
        cpuReq.write = write;
        cpuReq.addr  = addr;
        cpuReq.wdata = wdata;
        cpuReq.wmask = wmask;
        @(posedge clk);
        #1;
        cpuReq.valid = 1'b0;
        // busy stays up from the cycle after accept through the done cycle.
        checkBusy("busy", busy, 1'b1);
        while (!cpuResp.done) begin
            @(posedge clk);
            #1;
            checkBusy("busy", busy, 1'b1);
        end
        @(posedge clk);
        #1;
        checkBusy("busy", busy, 1'b0);
    endtask

    initial begin
        addrT        a;
        dataT        d;
        logic [31:0] r;
        rngState     = 32'h998e6dc9;
        rst          = 1'b1;
        cpuReq       = '0;
        memDelay     = '0;
        checkedCount = 0;
        for (int s = 0; s < numSets; s++) begin
            shLru[s] = 1'b0;
            for (int w = 0; w < `NUM_WAYS; w++) shValid[s][w] = 1'b0;
        end
        repeat (resetCycles) @(posedge clk);
        #1;
        rst = 1'b0;

        // cold reads miss, the repeats hit.
        for (int s = 0; s < numSets; s++) begin
            issueRequest(1'b0, wordAt(0, s), '0, '0);
            issueRequest(1'b0, wordAt(0, s), '0, '0);
        end

        // three tags in set 2, the third evicts the least recently used one.
        issueRequest(1'b0, wordAt(1, 2), '0, '0);
        issueRequest(1'b0, wordAt(0, 2), '0, '0);
        issueRequest(1'b0, wordAt(1, 2), '0, '0);
        issueRequest(1'b0, wordAt(2, 2), '0, '0);
        issueRequest(1'b0, wordAt(1, 2), '0, '0);
        issueRequest(1'b0, wordAt(0, 2), '0, '0);

        issueRequest(1'b1, wordAt(0, 1), 64'hdead_beef_0bad_f00d, 8'b0011_0101);
        issueRequest(1'b0, wordAt(0, 1), '0, '0);
        issueRequest(1'b1, wordAt(5, 3), 64'h0123_4567_89ab_cdef, 8'hf0);
        issueRequest(1'b0, wordAt(5, 3), '0, '0);

        repeat (numRandom) begin
            r       = nextRandom();
            a       = wordAt(int'(r[7:0] % 3), int'(r[9:8])) | addrT'(r[12:10]);
            d[63:32] = nextRandom();
            d[31:0]  = nextRandom();
            issueRequest(r[13], a, d, r[23:16]);
        end

        if (expQ.size() == 0 && checkedCount == numDirected + numRandom) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d responses were checked", checkedCount,
                     numDirected + numRandom);
            abortRun();
        end
    end

endmodule

// File: verification/dataCache_assertions.sv
`timescale 1ns/10ps

module dataCache_assertions import cache_pkg::*; (
    input logic    clk,
    input logic    rst,
    input cpuRespT cpuResp,
    input memReqT  memReq,
    input logic    memAck
);

    int unsigned failCount = 0;  // polled by the testbench.

    assert property (@(posedge clk) rst |=> !cpuResp.done && !memReq.valid)
        else begin
            failCount++;
            $error("done or memReq.valid high in the cycle after reset");
        end

    // the request is held unchanged until the memory acknowledges.
    assert property (@(posedge clk) disable iff (rst)
        memReq.valid && !memAck |=> memReq.valid && $stable(memReq))
        else begin
            failCount++;
            $error("memReq changed or dropped before memAck");
        end

    assert property (@(posedge clk) disable iff (rst) cpuResp.done |=> !cpuResp.done)
        else begin
            failCount++;
            $error("done held for more than one cycle");
        end

    assert property (@(posedge clk) disable iff (rst) cpuResp.done |-> !memReq.valid)
        else begin
            failCount++;
            $error("done raised while a memory request is pending");
        end

endmodule

bind dataCache dataCache_assertions dataCache_assertions_i (
    .clk     (clk),
    .rst     (rst),
    .cpuResp (cpuResp),
    .memReq  (memReq),
    .memAck  (memAck)
);

// File: verification/memoryModel.sv
`timescale 1ns/10ps
`include "cache_macros.svh"

module memoryModel import cache_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  memReqT     memReq,
    input  logic [1:0] delaySel,  // extra wait of 0 to 3 cycles.
    output logic       memAck,
    output dataT       memRdata
);

    dataT       mem [addrT];  // words never written read back the fill pattern.
    logic       pending;
    logic [1:0] waitCnt;

    function automatic dataT fillWord(input addrT wordAddr);
        return ((wordAddr >> 3) * 64'h9e37_79b9_7f4a_7c15) ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    always @(posedge clk) begin
        addrT wordAddr;
        dataT word;
        if (rst) begin
            pending  <= 1'b0;
            waitCnt  <= '0;
            memAck   <= 1'b0;
            memRdata <= '0;
        end else begin
            memAck <= 1'b0;
            if (memReq.valid && !pending && !memAck) begin
                pending <= 1'b1;
                waitCnt <= delaySel;
            end else if (pending && waitCnt != 0) begin
                waitCnt <= waitCnt - 1'b1;
            end else if (pending) begin
                wordAddr = {memReq.addr[`ADDR_WIDTH-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
                word     = mem.exists(wordAddr) ? mem[wordAddr] : fillWord(wordAddr);
                pending <= 1'b0;
                memAck  <= 1'b1;
                if (memReq.write) begin
                    for (int b = 0; b < `DATA_WIDTH / 8; b++) begin
                        if (memReq.wmask[b]) word[8*b +: 8] = memReq.wdata[8*b +: 8];
                    end
                    mem[wordAddr] = word;
                    memRdata     <= '0;
                end else begin
                    memRdata <= word;
                end
            end
        end
    end

endmodule

// File: src/dataCache.sv
`timescale 1ns/10ps

module dataCache import cache_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  cpuReqT  cpuReq,
    input  logic    memAck,
    input  dataT    memRdata,
    output cpuRespT cpuResp,
    output logic    busy,
    output memReqT  memReq
);

    // controller to array.
    addrT lookupAddr;
    logic fillEn;
    addrT fillAddr;
    dataT fillData;
    logic storeEn;
    dataT storeData;
    maskT storeMask;
    logic touchEn;

    // array back to controller.
    logic arrayHit;
    dataT arrayData;

    cacheController cacheController_i (
        .clk        (clk),
        .rst        (rst),
        .cpuReq     (cpuReq),
        .arrayHit   (arrayHit),
        .arrayData  (arrayData),
        .memAck     (memAck),
        .memRdata   (memRdata),
        .cpuResp    (cpuResp),
        .busy       (busy),
        .memReq     (memReq),
        .lookupAddr (lookupAddr),
        .fillEn     (fillEn),
        .fillAddr   (fillAddr),
        .fillData   (fillData),
        .storeEn    (storeEn),
        .storeData  (storeData),
        .storeMask  (storeMask),
        .touchEn    (touchEn)
    );

    // The controller does not need the hitting way.
    cacheArray cacheArray_i (
        .clk        (clk),
        .rst        (rst),
        .lookupAddr (lookupAddr),
        .fillEn     (fillEn),
        .fillAddr   (fillAddr),
        .fillData   (fillData),
        .storeEn    (storeEn),
        .storeData  (storeData),
        .storeMask  (storeMask),
        .touchEn    (touchEn),
        .hit        (arrayHit),
        .hitWay     (),
        .hitData    (arrayData)
    );

endmodule

// File: src/cacheController.sv
`timescale 1ns/10ps

module cacheController import cache_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  cpuReqT  cpuReq,
    input  logic    arrayHit,
    input  dataT    arrayData,
    input  logic    memAck,
    input  dataT    memRdata,
    output cpuRespT cpuResp,
    output logic    busy,
    output memReqT  memReq,
    output addrT    lookupAddr,
    output logic    fillEn,
    output addrT    fillAddr,
    output dataT    fillData,
    output logic    storeEn,
    output dataT    storeData,
    output maskT    storeMask,
    output logic    touchEn
);

    ctrlStateT state;
    ctrlStateT stateNext;
    logic      accept;

    // latched request and the response waiting to be pulsed.
    addrT addrQ;
    dataT wdataQ;
    maskT wmaskQ;
    logic hitQ;
    dataT rdataQ;

    assign accept = (state == IDLE) && cpuReq.valid;

    // ##################################################
    // state machine
    // ##################################################

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (cpuReq.valid) begin
                    if (cpuReq.write) begin
                        stateNext = WRITE_MEM;  // every store goes through to memory.
                    end else if (arrayHit) begin
                        stateNext = RESPOND;
                    end else begin
                        stateNext = READ_MEM;
                    end
                end
            end
            RESPOND: stateNext = IDLE;
            READ_MEM, WRITE_MEM: begin
                if (memAck) begin
                    stateNext = RESPOND;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // hit is captured at accept, so a write reports whether it merged.
    always_ff @(posedge clk) begin
        if (accept) begin
            addrQ  <= cpuReq.addr;
            wdataQ <= cpuReq.wdata;
            wmaskQ <= cpuReq.wmask;
            hitQ   <= arrayHit;
            rdataQ <= cpuReq.write ? '0 : arrayData;
        end else if ((state == READ_MEM) && memAck) begin
            rdataQ <= memRdata;
            hitQ   <= 1'b0;
        end
    end

    // ##################################################
    // array side
    // ##################################################

    assign lookupAddr = (state == IDLE) ? cpuReq.addr : addrQ;

    assign storeEn   = accept && cpuReq.write && arrayHit;
    assign storeData = cpuReq.wdata;
    assign storeMask = cpuReq.wmask;

    // Only read hits refresh the LRU bit.
    assign touchEn = accept && !cpuReq.write && arrayHit;

    assign fillEn   = (state == READ_MEM) && memAck;
    assign fillAddr = addrQ;
    assign fillData = memRdata;

    // ##################################################
    // cpu and memory side
    // ##################################################

    assign busy = (state != IDLE);

    always_comb begin
        cpuResp.done  = (state == RESPOND);
        cpuResp.hit   = hitQ;
        cpuResp.rdata = rdataQ;
    end

    always_comb begin
        memReq.valid = (state == READ_MEM) || (state == WRITE_MEM);
        memReq.write = (state == WRITE_MEM);
        memReq.addr  = addrQ;
        memReq.wdata = (state == WRITE_MEM) ? wdataQ : '0;
        memReq.wmask = (state == WRITE_MEM) ? wmaskQ : '0;
    end

endmodule

// File: src/cacheArray.sv
`timescale 1ns/10ps
`include "cache_macros.svh"

module cacheArray import cache_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  addrT lookupAddr,
    input  logic fillEn,
    input  addrT fillAddr,
    input  dataT fillData,
    input  logic storeEn,
    input  dataT storeData,
    input  maskT storeMask,
    input  logic touchEn,
    output logic hit,
    output wayT  hitWay,
    output dataT hitData
);

    localparam int numSets  = 1 << `INDEX_BITS;
    localparam int numBytes = `DATA_WIDTH / 8;

    // ##################################################
    // storage
    // ##################################################

    dataT dataMem [`NUM_WAYS][numSets];
    tagT  tagMem  [`NUM_WAYS][numSets];

    logic [`NUM_WAYS-1:0] validQ [numSets];
    wayT                  lruQ   [numSets];  // names the victim when the set is full.

    // ##################################################
    // lookup
    // ##################################################

    indexT                lookupIdx;
    tagT                  lookupTag;
    logic [`NUM_WAYS-1:0] wayHit;

    assign lookupIdx = lookupAddr[`OFFSET_BITS +: `INDEX_BITS];
    assign lookupTag = lookupAddr[`ADDR_WIDTH-1 -: `TAG_BITS];

    always_comb begin
        for (int w = 0; w < `NUM_WAYS; w++) begin
            wayHit[w] = validQ[lookupIdx][w] && (tagMem[w][lookupIdx] == lookupTag);
        end
    end

    assign hit = |wayHit;

    // lowest hitting way wins, though a tag is never resident twice.
    always_comb begin
        hitWay = '0;
        for (int w = `NUM_WAYS - 1; w >= 0; w--) begin
            if (wayHit[w]) begin
                hitWay = wayT'(w);
            end
        end
    end

    assign hitData = hit ? dataMem[hitWay][lookupIdx] : '0;

    // ##################################################
    // replacement
    // ##################################################

    indexT fillIdx;
    tagT   fillTag;
    wayT   victimWay;

    assign fillIdx = fillAddr[`OFFSET_BITS +: `INDEX_BITS];
    assign fillTag = fillAddr[`ADDR_WIDTH-1 -: `TAG_BITS];

    // first invalid way, otherwise whatever the LRU bit points at.
    always_comb begin
        victimWay = lruQ[fillIdx];
        for (int w = `NUM_WAYS - 1; w >= 0; w--) begin
            if (!validQ[fillIdx][w]) begin
                victimWay = wayT'(w);
            end
        end
    end

    // ##################################################
    // updates
    // ##################################################

    always_ff @(posedge clk) begin
        if (fillEn) begin
            dataMem[victimWay][fillIdx] <= fillData;
            tagMem[victimWay][fillIdx]  <= fillTag;
        end else if (storeEn && hit) begin
            for (int b = 0; b < numBytes; b++) begin
                if (storeMask[b]) begin
                    dataMem[hitWay][lookupIdx][8*b +: 8] <= storeData[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < numSets; s++) begin
                validQ[s] <= '0;
                lruQ[s]   <= '0;
            end
        end else begin
            if (fillEn) begin
                validQ[fillIdx][victimWay] <= 1'b1;
                lruQ[fillIdx]              <= ~victimWay;  // the other way goes next.
            end
            if (touchEn && hit) begin
                lruQ[lookupIdx] <= ~hitWay;
            end
        end
    end

endmodule

// File: src/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

    typedef logic [`ADDR_WIDTH-1:0]       addrT;
    typedef logic [`DATA_WIDTH-1:0]       dataT;
    typedef logic [`DATA_WIDTH/8-1:0]     maskT;     // one enable per byte lane.
    typedef logic [`TAG_BITS-1:0]         tagT;
    typedef logic [`INDEX_BITS-1:0]       indexT;
    typedef logic [$clog2(`NUM_WAYS)-1:0] wayT;

    // load/store request from the core, valid is a one-cycle strobe.
    typedef struct packed {
        logic valid;
        logic write;
        addrT addr;
        dataT wdata;
        maskT wmask;
    } cpuReqT;

    typedef struct packed {
        logic done;
        logic hit;
        dataT rdata;
    } cpuRespT;

    // valid is held with stable fields until the memory acknowledges.
    typedef struct packed {
        logic valid;
        logic write;
        addrT addr;
        dataT wdata;
        maskT wmask;
    } memReqT;

    typedef enum logic [1:0] {
        IDLE,
        RESPOND,
        READ_MEM,
        WRITE_MEM
    } ctrlStateT;

endpackage

// File: src/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ##################################################
// cache geometry
// ##################################################

// byte address and data word.
`define ADDR_WIDTH 64
`define DATA_WIDTH 64

// one 64-bit word per line, so the offset selects a byte in the word.
`define OFFSET_BITS 3

// four sets.
`define INDEX_BITS 2

// everything above the index is tag.
`define TAG_BITS (`ADDR_WIDTH - `INDEX_BITS - `OFFSET_BITS)

`define NUM_WAYS 2

`endif
